// ==== include/golem_defines.svh ====
`ifndef GOLEM_DEFINES_SVH
`define GOLEM_DEFINES_SVH

// datapath and memory sizes
`define GOLEM_DATA_W      32
`define GOLEM_PC_W        8
`define GOLEM_IMEM_DEPTH  256

// register file
`define GOLEM_REG_ADDR_W  5
`define GOLEM_REG_COUNT   32

// instruction field widths
`define GOLEM_OP_W        6
`define GOLEM_IMM_W       16
`define GOLEM_TARGET_W    26

`endif

// ==== hdl/golem_pkg.sv ====
`default_nettype none

`include "golem_defines.svh"

package golem_pkg;

    typedef enum logic [`GOLEM_OP_W-1:0] {
        op_rtype = 6'd0,
        op_j     = 6'd2,
        op_beq   = 6'd4,
        op_bne   = 6'd5,
        op_addi  = 6'd8,
        op_addiu = 6'd9,
        op_slti  = 6'd10,
        op_andi  = 6'd12,
        op_ori   = 6'd13
    } opcode_e;

    // only meaningful when opcode is op_rtype
    typedef enum logic [5:0] {
        fn_sll  = 6'd0,
        fn_srl  = 6'd2,
        fn_slt  = 6'd24,
        fn_add  = 6'd32,
        fn_addu = 6'd33,
        fn_sub  = 6'd34,
        fn_subu = 6'd35,
        fn_and  = 6'd36,
        fn_or   = 6'd37
    } funct_e;

    // one instruction word, three decodings
    typedef union packed {
        struct packed {
            opcode_e                      opcode;
            logic [`GOLEM_REG_ADDR_W-1:0] rs;
            logic [`GOLEM_REG_ADDR_W-1:0] rt;
            logic [`GOLEM_REG_ADDR_W-1:0] rd;
            logic [4:0]                   shamt;
            funct_e                       funct;
        } r_view;
        struct packed {
            opcode_e                      opcode;
            logic [`GOLEM_REG_ADDR_W-1:0] rs;
            logic [`GOLEM_REG_ADDR_W-1:0] rt;
            logic [`GOLEM_IMM_W-1:0]      imm;
        } i_view;
        struct packed {
            opcode_e                      opcode;
            logic [`GOLEM_TARGET_W-1:0]   target;
        } j_view;
    } instr_t;

    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_fetch = 2'd1,
        st_exec  = 2'd2,
        st_halt  = 2'd3
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== hdl/instr_mem.sv ====
`default_nettype none

`include "golem_defines.svh"

module instr_mem
    import golem_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   imem_we,
    input  wire logic [`GOLEM_PC_W-1:0] load_addr,
    input  wire instr_t                 load_data,
    input  wire logic [`GOLEM_PC_W-1:0] pc,
    input  wire logic                   fetch_en,
    output instr_t                      instr
);

    instr_t mem [`GOLEM_IMEM_DEPTH];

    // load port, only active while the core is not running
    always_ff @(posedge clk)
    begin
        if (imem_we)
        begin
            mem[load_addr] <= load_data;
        end
    end

    // registered read, instr is held through the execute cycle
    always_ff @(posedge clk)
    begin
        if (fetch_en)
        begin
            instr <= mem[pc];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/program_counter.sv ====
`default_nettype none

`include "golem_defines.svh"

module program_counter (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   pc_clear,
    input  wire logic                   exec_en,
    input  wire logic                   branch_taken,
    input  wire logic [`GOLEM_PC_W-1:0] jump_target,
    input  wire logic                   imem_we,
    input  wire logic [`GOLEM_PC_W-1:0] load_addr,
    output logic      [`GOLEM_PC_W-1:0] pc,
    output logic                        at_end
);

    // one extra bit so a full memory still reaches its end
    logic [`GOLEM_PC_W:0] pc_q;
    logic [`GOLEM_PC_W:0] prog_len;
    logic [`GOLEM_PC_W:0] load_len;
    // set by the first load after a run, so a reload starts a new length
    logic                 len_open;

    assign load_len = {1'b0, load_addr} + 1'b1;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            pc_q <= '0;
        end
        else if (pc_clear)
        begin
            pc_q <= '0;
        end
        else if (exec_en)
        begin
            pc_q <= branch_taken ? {1'b0, jump_target} : pc_q + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            prog_len <= '0;
            len_open <= 1'b0;
        end
        else if (pc_clear)
        begin
            len_open <= 1'b0;
        end
        else if (imem_we)
        begin
            len_open <= 1'b1;
            if (!len_open || load_len > prog_len)
            begin
                prog_len <= load_len;
            end
        end
    end

    assign pc     = pc_q[`GOLEM_PC_W-1:0];
    assign at_end = (pc_q == prog_len);

endmodule

`default_nettype wire

// ==== hdl/exec_ctrl.sv ====
`default_nettype none

module exec_ctrl
    import golem_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic load_en,
    input  wire logic run,
    input  wire logic at_end,
    output logic      imem_we,
    output logic      pc_clear,
    output logic      fetch_en,
    output logic      exec_en,
    output logic      done
);

    ctrl_state_e state;
    ctrl_state_e state_next;
    logic        stopped;

    // program may only change while nothing is running
    assign stopped = (state == st_idle) || (state == st_halt);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= st_idle;
        end
        else
        begin
            state <= state_next;
        end
    end

    always_comb
    begin
        state_next = state;
        case (state)
            st_idle, st_halt:
            begin
                if (run)
                begin
                    state_next = st_fetch;
                end
            end
            st_fetch:
            begin
                // end of program is checked before any read goes out
                state_next = at_end ? st_halt : st_exec;
            end
            st_exec:
            begin
                state_next = st_fetch;
            end
            default:
            begin
                state_next = st_idle;
            end
        endcase
    end

    assign imem_we  = load_en && stopped;
    assign pc_clear = run && stopped;
    assign fetch_en = (state == st_fetch) && !at_end;
    assign exec_en  = (state == st_exec);
    assign done     = (state == st_halt);

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`default_nettype none

`include "golem_defines.svh"

module reg_file (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic [`GOLEM_REG_ADDR_W-1:0] rs_addr,
    input  wire logic [`GOLEM_REG_ADDR_W-1:0] rt_addr,
    output logic      [`GOLEM_DATA_W-1:0]     rs_data,
    output logic      [`GOLEM_DATA_W-1:0]     rt_data,
    input  wire logic                         wr_en,
    input  wire logic [`GOLEM_REG_ADDR_W-1:0] wr_addr,
    input  wire logic [`GOLEM_DATA_W-1:0]     wr_data,
    input  wire logic [`GOLEM_REG_ADDR_W-1:0] reg_sel,
    output logic      [`GOLEM_DATA_W-1:0]     reg_data
);

    logic [`GOLEM_DATA_W-1:0] regs [`GOLEM_REG_COUNT];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `GOLEM_REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        // register 0 is never written, so it stays zero from reset
        else if (wr_en && wr_addr != '0)
        begin
            regs[wr_addr] <= wr_data;
        end
    end

    // two operand ports and one observation port
    assign rs_data  = regs[rs_addr];
    assign rt_data  = regs[rt_addr];
    assign reg_data = regs[reg_sel];

endmodule

`default_nettype wire

// ==== hdl/exec_unit.sv ====
`default_nettype none

`include "golem_defines.svh"

module exec_unit
    import golem_pkg::*;
(
    input  wire instr_t                       instr,
    input  wire logic [`GOLEM_PC_W-1:0]       pc,
    input  wire logic                         exec_en,
    input  wire logic [`GOLEM_DATA_W-1:0]     rs_data,
    input  wire logic [`GOLEM_DATA_W-1:0]     rt_data,
    output logic      [`GOLEM_REG_ADDR_W-1:0] rs_addr,
    output logic      [`GOLEM_REG_ADDR_W-1:0] rt_addr,
    output logic                              wr_en,
    output logic      [`GOLEM_REG_ADDR_W-1:0] wr_addr,
    output logic      [`GOLEM_DATA_W-1:0]     wr_data,
    output logic                              branch_taken,
    output logic      [`GOLEM_PC_W-1:0]       jump_target
);

    logic [`GOLEM_DATA_W-1:0] imm_sext;
    logic [`GOLEM_DATA_W-1:0] imm_zext;
    logic [`GOLEM_PC_W-1:0]   pc_inc;
    logic                     wr_ok;
    logic                     take;

    // rs and rt sit in the same bits in the R and I views
    assign rs_addr = instr.i_view.rs;
    assign rt_addr = instr.i_view.rt;

    assign imm_sext = {{(`GOLEM_DATA_W-`GOLEM_IMM_W){instr.i_view.imm[`GOLEM_IMM_W-1]}},
                       instr.i_view.imm};
    assign imm_zext = {{(`GOLEM_DATA_W-`GOLEM_IMM_W){1'b0}}, instr.i_view.imm};
    assign pc_inc   = pc + 1'b1;

    always_comb
    begin
        wr_ok       = 1'b0;
        take        = 1'b0;
        wr_addr     = instr.i_view.rt;
        wr_data     = '0;
        jump_target = pc_inc;
        case (instr.r_view.opcode)
            op_rtype:
            begin
                wr_addr = instr.r_view.rd;
                wr_ok   = 1'b1;
                case (instr.r_view.funct)
                    fn_sll:          wr_data = rt_data << instr.r_view.shamt;
                    fn_srl:          wr_data = rt_data >> instr.r_view.shamt;
                    fn_slt:
                    begin
                        wr_data = {{(`GOLEM_DATA_W-1){1'b0}},
                                   $signed(rs_data) < $signed(rt_data)};
                    end
                    fn_add, fn_addu: wr_data = rs_data + rt_data;
                    fn_sub, fn_subu: wr_data = rs_data - rt_data;
                    fn_and:          wr_data = rs_data & rt_data;
                    fn_or:           wr_data = rs_data | rt_data;
                    // unknown funct writes nothing
                    default:         wr_ok   = 1'b0;
                endcase
            end
            op_addi, op_addiu:
            begin
                wr_ok   = 1'b1;
                wr_data = rs_data + imm_sext;
            end
            op_slti:
            begin
                wr_ok   = 1'b1;
                wr_data = {{(`GOLEM_DATA_W-1){1'b0}},
                           $signed(rs_data) < $signed(imm_sext)};
            end
            op_andi:
            begin
                wr_ok   = 1'b1;
                wr_data = rs_data & imm_zext;
            end
            op_ori:
            begin
                wr_ok   = 1'b1;
                wr_data = rs_data | imm_zext;
            end
            op_beq, op_bne:
            begin
                // offset is relative to the next pc
                jump_target = pc_inc + imm_sext[`GOLEM_PC_W-1:0];
                take = (rs_data == rt_data) ^ (instr.r_view.opcode == op_bne);
            end
            op_j:
            begin
                jump_target = instr.j_view.target[`GOLEM_PC_W-1:0];
                take        = 1'b1;
            end
            default:
            begin
                wr_ok = 1'b0;
            end
        endcase
    end

    assign wr_en        = exec_en && wr_ok;
    assign branch_taken = exec_en && take;

endmodule

`default_nettype wire

// ==== hdl/golem_top.sv ====
`default_nettype none

`include "golem_defines.svh"

module golem_top
    import golem_pkg::*;
(
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         load_en,
    input  wire logic [`GOLEM_PC_W-1:0]       load_addr,
    input  wire instr_t                       load_data,
    input  wire logic                         run,
    input  wire logic [`GOLEM_REG_ADDR_W-1:0] reg_sel,
    output logic                              done,
    output logic      [`GOLEM_DATA_W-1:0]     reg_data
);

    logic                         imem_we;
    logic                         pc_clear;
    logic                         fetch_en;
    logic                         exec_en;
    logic [`GOLEM_PC_W-1:0]       pc;
    logic                         at_end;
    instr_t                       instr;
    logic [`GOLEM_REG_ADDR_W-1:0] rs_addr;
    logic [`GOLEM_REG_ADDR_W-1:0] rt_addr;
    logic [`GOLEM_DATA_W-1:0]     rs_data;
    logic [`GOLEM_DATA_W-1:0]     rt_data;
    logic                         wr_en;
    logic [`GOLEM_REG_ADDR_W-1:0] wr_addr;
    logic [`GOLEM_DATA_W-1:0]     wr_data;
    logic                         branch_taken;
    logic [`GOLEM_PC_W-1:0]       jump_target;

    exec_ctrl u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .load_en  (load_en),
        .run      (run),
        .at_end   (at_end),
        .imem_we  (imem_we),
        .pc_clear (pc_clear),
        .fetch_en (fetch_en),
        .exec_en  (exec_en),
        .done     (done)
    );

    program_counter u_pc (
        .clk          (clk),
        .rst_n        (rst_n),
        .pc_clear     (pc_clear),
        .exec_en      (exec_en),
        .branch_taken (branch_taken),
        .jump_target  (jump_target),
        .imem_we      (imem_we),
        .load_addr    (load_addr),
        .pc           (pc),
        .at_end       (at_end)
    );

    instr_mem u_imem (
        .clk       (clk),
        .imem_we   (imem_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .pc        (pc),
        .fetch_en  (fetch_en),
        .instr     (instr)
    );

    reg_file u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs_addr  (rs_addr),
        .rt_addr  (rt_addr),
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .reg_sel  (reg_sel),
        .reg_data (reg_data)
    );

    exec_unit u_exec (
        .instr        (instr),
        .pc           (pc),
        .exec_en      (exec_en),
        .rs_data      (rs_data),
        .rt_data      (rt_data),
        .rs_addr      (rs_addr),
        .rt_addr      (rt_addr),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .branch_taken (branch_taken),
        .jump_target  (jump_target)
    );

endmodule

`default_nettype wire

// ==== dv/golem_assertions.sv ====
`default_nettype none

module golem_assertions
    import golem_pkg::*;
(
    input wire logic        clk,
    input wire logic        rst_n,
    input wire ctrl_state_e state,
    input wire logic        done,
    input wire logic        exec_en,
    input wire logic        imem_we
);

    // failure count, seen by the testbench
    int fail_cnt = 0;

    // halt and execute never overlap
    no_done_in_exec: assert property (
        @(posedge clk) disable iff (!rst_n) !(done && exec_en)
    )
    else
    begin
        fail_cnt++;
        $error("done and exec_en are high together");
    end

    // every execute cycle comes straight from a fetch
    exec_after_fetch: assert property (
        @(posedge clk) disable iff (!rst_n) (state == st_exec) |-> ($past(state) == st_fetch)
    )
    else
    begin
        fail_cnt++;
        $error("st_exec entered from a state other than st_fetch");
    end

    // program is frozen while running
    load_when_stopped: assert property (
        @(posedge clk) disable iff (!rst_n) imem_we |-> (state == st_idle || state == st_halt)
    )
    else
    begin
        fail_cnt++;
        $error("imem_we high while the core is running");
    end

endmodule

bind exec_ctrl golem_assertions u_assert (
    .clk     (clk),
    .rst_n   (rst_n),
    .state   (state),
    .done    (done),
    .exec_en (exec_en),
    .imem_we (imem_we)
);

`default_nettype wire

// ==== dv/golem_tb.sv ====
`default_nettype none

`include "golem_defines.svh"

module golem_tb
    import golem_pkg::*;
();

    logic                         clk;
    logic                         rst_n;
    logic                         load_en;
    logic [`GOLEM_PC_W-1:0]       load_addr;
    instr_t                       load_data;
    logic                         run;
    logic [`GOLEM_REG_ADDR_W-1:0] reg_sel;
    logic                         done;
    logic [`GOLEM_DATA_W-1:0]     reg_data;

    integer                   seed;
    logic [31:0]              rnd;
    logic [15:0]              neg_imm;
    logic [15:0]              pos_imm;
    logic [15:0]              mask_imm;
    logic [15:0]              new_imm;
    int                       sh1;
    int                       sh2;
    // program table, then the registers to check after done
    instr_t                   prog [$];
    int                       exp_reg [$];
    logic [`GOLEM_DATA_W-1:0] exp_val [$];
    // expected register contents, carried across runs
    logic [`GOLEM_DATA_W-1:0] ev [`GOLEM_REG_COUNT];

    golem_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .run       (run),
        .reg_sel   (reg_sel),
        .done      (done),
        .reg_data  (reg_data)
    );

    always #4 clk = ~clk;

    function automatic instr_t rtype_word(funct_e fn, int rd, int rs, int rt, int shamt);
        instr_t w;
        w = '0;
        w.r_view.opcode = op_rtype;
        w.r_view.rs     = rs[4:0];
        w.r_view.rt     = rt[4:0];
        w.r_view.rd     = rd[4:0];
        w.r_view.shamt  = shamt[4:0];
        w.r_view.funct  = fn;
        return w;
    endfunction

    function automatic instr_t itype_word(opcode_e op, int rt, int rs, logic [15:0] imm);
        instr_t w;
        w = '0;
        w.i_view.opcode = op;
        w.i_view.rs     = rs[4:0];
        w.i_view.rt     = rt[4:0];
        w.i_view.imm    = imm;
        return w;
    endfunction

    function automatic instr_t jump_word(int target);
        instr_t w;
        w = '0;
        w.j_view.opcode = op_j;
        w.j_view.target = target[25:0];
        return w;
    endfunction

    function automatic logic [31:0] sign_ext(logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic logic [31:0] zero_ext(logic [15:0] v);
        return {16'd0, v};
    endfunction

    function automatic logic [31:0] less_signed(logic [31:0] a, logic [31:0] b);
        return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
        if (got !== expected)
        begin
            $display("SOME TESTS FAILED");
            $fatal(1, "error at time %0t: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic expect_reg(int idx);
        exp_reg.push_back(idx);
        exp_val.push_back(ev[idx]);
    endtask

    task automatic load_program();
        for (int i = 0; i < prog.size(); i++)
        begin
            load_en   = 1'b1;
            load_addr = i[`GOLEM_PC_W-1:0];
            load_data = prog[i];
            @(negedge clk);
        end
        load_en = 1'b0;
    endtask

    // run pulse, then wait for done; optionally try a load mid-run
    task automatic start_and_wait(int executed, bit inject, instr_t stray);
        int cycles;
        int limit;
        int last;
        limit = 4 * executed + 100;
        last  = prog.size() - 1;
        run   = 1'b1;
        @(negedge clk);
        run    = 1'b0;
        cycles = 1;
        while (!done)
        begin
            if (cycles >= limit)
            begin
                $display("SOME TESTS FAILED");
                $fatal(1, "timeout: done did not rise within %0d cycles", limit);
            end
            load_en = inject && (cycles == 3);
            if (inject && cycles == 3)
            begin
                load_addr = last[`GOLEM_PC_W-1:0];
                load_data = stray;
            end
            @(negedge clk);
            cycles++;
        end
        load_en = 1'b0;
        // two cycles per instruction, one fetch at the end, one into halt
        check_value("done latency", cycles, 2 * executed + 2);
    endtask

    task automatic check_registers();
        int idx;
        for (int i = 0; i < exp_reg.size(); i++)
        begin
            idx     = exp_reg[i];
            reg_sel = idx[`GOLEM_REG_ADDR_W-1:0];
            @(posedge clk);
            check_value($sformatf("reg_data for r%0d", idx), reg_data, exp_val[i]);
            @(negedge clk);
        end
    endtask

    task automatic run_program(int executed, bit inject, instr_t stray);
        load_program();
        start_and_wait(executed, inject, stray);
        check_registers();
        prog.delete();
        exp_reg.delete();
        exp_val.delete();
    endtask

    initial
    begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        run       = 1'b0;
        reg_sel   = '0;
        seed      = 8;
        for (int i = 0; i < `GOLEM_REG_COUNT; i++)
        begin
            ev[i] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        rnd      = $random(seed);
        neg_imm  = rnd[15:0] | 16'h8000;
        rnd      = $random(seed);
        pos_imm  = rnd[15:0] & 16'h7fff;
        rnd      = $random(seed);
        mask_imm = rnd[15:0] | 16'h8000;
        rnd      = $random(seed);
        sh1      = int'(rnd[4:0]) | 1;
        rnd      = $random(seed);
        sh2      = int'(rnd[4:0]) | 1;
        rnd      = $random(seed);
        new_imm  = rnd[15:0];

        // immediates, sign extension for arithmetic, zero extension for logic
        prog.push_back(itype_word(op_addi, 1, 0, neg_imm));
        prog.push_back(itype_word(op_addiu, 2, 0, pos_imm));
        prog.push_back(itype_word(op_addi, 3, 1, pos_imm));
        prog.push_back(itype_word(op_andi, 4, 1, mask_imm));
        prog.push_back(itype_word(op_ori, 5, 0, mask_imm));
        prog.push_back(itype_word(op_slti, 6, 1, pos_imm));
        prog.push_back(itype_word(op_slti, 7, 2, neg_imm));
        prog.push_back(itype_word(op_addiu, 8, 2, neg_imm));
        ev[1] = sign_ext(neg_imm);
        ev[2] = sign_ext(pos_imm);
        ev[3] = ev[1] + sign_ext(pos_imm);
        ev[4] = ev[1] & zero_ext(mask_imm);
        ev[5] = zero_ext(mask_imm);
        ev[6] = less_signed(ev[1], sign_ext(pos_imm));
        ev[7] = less_signed(ev[2], sign_ext(neg_imm));
        ev[8] = ev[2] + sign_ext(neg_imm);
        for (int r = 1; r <= 8; r++)
        begin
            expect_reg(r);
        end
        run_program(8, 1'b0, '0);

        // R-type on the values above, last one targets r0
        prog.push_back(rtype_word(fn_add, 9, 1, 2, 0));
        prog.push_back(rtype_word(fn_addu, 10, 3, 5, 0));
        prog.push_back(rtype_word(fn_sub, 11, 2, 1, 0));
        prog.push_back(rtype_word(fn_subu, 12, 1, 5, 0));
        prog.push_back(rtype_word(fn_and, 13, 1, 5, 0));
        prog.push_back(rtype_word(fn_or, 14, 2, 5, 0));
        prog.push_back(rtype_word(fn_slt, 15, 1, 2, 0));
        prog.push_back(rtype_word(fn_slt, 16, 2, 1, 0));
        prog.push_back(rtype_word(fn_sll, 17, 0, 1, sh1));
        prog.push_back(rtype_word(fn_srl, 18, 0, 1, sh2));
        prog.push_back(rtype_word(fn_add, 0, 1, 2, 0));
        ev[9]  = ev[1] + ev[2];
        ev[10] = ev[3] + ev[5];
        ev[11] = ev[2] - ev[1];
        ev[12] = ev[1] - ev[5];
        ev[13] = ev[1] & ev[5];
        ev[14] = ev[2] | ev[5];
        ev[15] = less_signed(ev[1], ev[2]);
        ev[16] = less_signed(ev[2], ev[1]);
        ev[17] = ev[1] << sh1;
        ev[18] = ev[1] >> sh2;
        expect_reg(0);
        for (int r = 9; r <= 18; r++)
        begin
            expect_reg(r);
        end
        run_program(11, 1'b0, '0);

        // taken beq skips 3, bne at 4 falls through, j skips 7
        prog.push_back(itype_word(op_addi, 20, 0, 16'd5));
        prog.push_back(itype_word(op_addi, 21, 0, 16'd5));
        prog.push_back(itype_word(op_beq, 21, 20, 16'd1));
        prog.push_back(itype_word(op_addi, 22, 0, 16'd111));
        prog.push_back(itype_word(op_bne, 21, 20, 16'd1));
        prog.push_back(itype_word(op_addi, 23, 0, 16'd222));
        prog.push_back(jump_word(8));
        prog.push_back(itype_word(op_addi, 24, 0, 16'd333));
        prog.push_back(itype_word(op_addi, 25, 0, 16'd444));
        ev[20] = 32'd5;
        ev[21] = 32'd5;
        ev[23] = 32'd222;
        ev[25] = 32'd444;
        for (int r = 20; r <= 25; r++)
        begin
            expect_reg(r);
        end
        run_program(7, 1'b0, '0);

        // shorter reload, a stray load while running must be ignored
        prog.push_back(itype_word(op_addi, 26, 0, new_imm));
        prog.push_back(itype_word(op_ori, 27, 0, 16'h00ff));
        prog.push_back(itype_word(op_addi, 20, 0, 16'hfffd));
        ev[20] = sign_ext(16'hfffd);
        ev[26] = sign_ext(new_imm);
        ev[27] = 32'h0000_00ff;
        expect_reg(20);
        expect_reg(25);
        expect_reg(26);
        expect_reg(27);
        run_program(3, 1'b1, itype_word(op_addi, 20, 0, 16'd99));

        if (u_dut.u_ctrl.u_assert.fail_cnt == 0)
        begin
            $display("ALL TESTS PASSED");
        end
        else
        begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
hdl/golem_pkg.sv
hdl/instr_mem.sv
hdl/program_counter.sv
hdl/exec_ctrl.sv
hdl/reg_file.sv
hdl/exec_unit.sv
hdl/golem_top.sv
dv/golem_assertions.sv
dv/golem_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall
TOP        ?= golem_tb
FILELIST   ?= sources.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
